/* logic/vga_pkg.sv */
// shared register map, field widths and timing phase encoding
// register index comes from byte address bits 4 to 2

`default_nettype none

package vga_pkg;

  ////////////////////////////////////////////////////////////
  // bus and field widths
  ////////////////////////////////////////////////////////////

  // apb address and data
  localparam int ADDR_W  = 5;
  localparam int DATA_W  = 32;

  // visible length and position counters
  localparam int LEN_W   = 16;
  // each sync or porch size
  localparam int PORCH_W = 8;
  // pixel clock divider field
  localparam int DIV_W   = 8;
  // one colour channel of the test pattern
  localparam int COLOR_W = 5;

  ////////////////////////////////////////////////////////////
  // register word indices
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    REG_CTRL = 3'd0,
    REG_HVVL = 3'd1,
    REG_HTIM = 3'd2,
    REG_VTIM = 3'd3,
    REG_STAT = 3'd4
  } reg_idx_e;

  // timing phases in the order a line or frame walks through them
  typedef enum logic [1:0] {
    PH_SYNC,
    PH_BACK,
    PH_VISIBLE,
    PH_FRONT
  } phase_e;

  ////////////////////////////////////////////////////////////
  // field positions
  ////////////////////////////////////////////////////////////

  // control register
  localparam int CTRL_EN      = 0;
  localparam int CTRL_HIE     = 1;
  localparam int CTRL_VIE     = 2;
  localparam int CTRL_HSPOL   = 3;
  localparam int CTRL_VSPOL   = 4;
  // divider occupies bits 15 to 8
  localparam int CTRL_DIV_LSB = 8;

  // visible sizes, horizontal in the low half
  localparam int HVVL_HV_LSB  = 0;
  localparam int HVVL_VV_LSB  = 16;

  // htim and vtim share one layout
  localparam int TIM_FP_LSB   = 0;
  localparam int TIM_SN_LSB   = 8;
  localparam int TIM_BP_LSB   = 16;

  // status flags
  localparam int STAT_HIF     = 0;
  localparam int STAT_VIF     = 1;

endpackage

`default_nettype wire

/* logic/vga_regs.sv */
// apb register file; every access completes in its access phase
// status flags: a set from the timing wins, writing 0 clears, writing 1 keeps

`timescale 1ns/1ps
`default_nettype none

module vga_regs (
  input  wire logic                         clk_i,
  input  wire logic                         arst_n_i,
  input  wire logic                         psel_i,
  input  wire logic                         penable_i,
  input  wire logic                         pwrite_i,
  input  wire logic [vga_pkg::ADDR_W-1:0]   paddr_i,
  input  wire logic [vga_pkg::DATA_W-1:0]   pwdata_i,
  input  wire logic                         hend_i,
  input  wire logic                         vend_i,
  output logic      [vga_pkg::DATA_W-1:0]   prdata_o,
  output logic                              en_o,
  output logic                              hspol_o,
  output logic                              vspol_o,
  output logic      [vga_pkg::DIV_W-1:0]    div_o,
  output logic      [vga_pkg::LEN_W-1:0]    hvlen_o,
  output logic      [vga_pkg::LEN_W-1:0]    vvlen_o,
  output logic      [vga_pkg::PORCH_W-1:0]  hsn_o,
  output logic      [vga_pkg::PORCH_W-1:0]  hbp_o,
  output logic      [vga_pkg::PORCH_W-1:0]  hfp_o,
  output logic      [vga_pkg::PORCH_W-1:0]  vsn_o,
  output logic      [vga_pkg::PORCH_W-1:0]  vbp_o,
  output logic      [vga_pkg::PORCH_W-1:0]  vfp_o,
  output logic                              irq_o
);

  vga_pkg::reg_idx_e reg_idx;
  logic              wr_acc;
  logic              rd_acc;
  // control bits kept apart from the divider
  logic              hie_q;
  logic              vie_q;
  logic              hif_q;
  logic              vif_q;

  // word index from address bits 4 to 2
  assign reg_idx = vga_pkg::reg_idx_e'(paddr_i[vga_pkg::ADDR_W-1:2]);
  assign wr_acc  = psel_i & penable_i & pwrite_i;
  assign rd_acc  = psel_i & penable_i & ~pwrite_i;

  ////////////////////////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_o    <= 1'b0;
      hie_q   <= 1'b0;
      vie_q   <= 1'b0;
      hspol_o <= 1'b0;
      vspol_o <= 1'b0;
      div_o   <= '0;
      hvlen_o <= '0;
      vvlen_o <= '0;
      hsn_o   <= '0;
      hbp_o   <= '0;
      hfp_o   <= '0;
      vsn_o   <= '0;
      vbp_o   <= '0;
      vfp_o   <= '0;
    end else if (wr_acc) begin
      case (reg_idx)
        vga_pkg::REG_CTRL: begin
          en_o    <= pwdata_i[vga_pkg::CTRL_EN];
          hie_q   <= pwdata_i[vga_pkg::CTRL_HIE];
          vie_q   <= pwdata_i[vga_pkg::CTRL_VIE];
          hspol_o <= pwdata_i[vga_pkg::CTRL_HSPOL];
          vspol_o <= pwdata_i[vga_pkg::CTRL_VSPOL];
          div_o   <= pwdata_i[vga_pkg::CTRL_DIV_LSB +: vga_pkg::DIV_W];
        end
        vga_pkg::REG_HVVL: begin
          hvlen_o <= pwdata_i[vga_pkg::HVVL_HV_LSB +: vga_pkg::LEN_W];
          vvlen_o <= pwdata_i[vga_pkg::HVVL_VV_LSB +: vga_pkg::LEN_W];
        end
        vga_pkg::REG_HTIM: begin
          hfp_o <= pwdata_i[vga_pkg::TIM_FP_LSB +: vga_pkg::PORCH_W];
          hsn_o <= pwdata_i[vga_pkg::TIM_SN_LSB +: vga_pkg::PORCH_W];
          hbp_o <= pwdata_i[vga_pkg::TIM_BP_LSB +: vga_pkg::PORCH_W];
        end
        vga_pkg::REG_VTIM: begin
          vfp_o <= pwdata_i[vga_pkg::TIM_FP_LSB +: vga_pkg::PORCH_W];
          vsn_o <= pwdata_i[vga_pkg::TIM_SN_LSB +: vga_pkg::PORCH_W];
          vbp_o <= pwdata_i[vga_pkg::TIM_BP_LSB +: vga_pkg::PORCH_W];
        end
        // status is handled below, undefined words ignore writes
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // status flags and interrupt
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hif_q <= 1'b0;
      vif_q <= 1'b0;
    end else if (wr_acc && reg_idx == vga_pkg::REG_STAT) begin
      // a written 0 drops the flag unless a new end arrives now
      hif_q <= hend_i | (hif_q & pwdata_i[vga_pkg::STAT_HIF]);
      vif_q <= vend_i | (vif_q & pwdata_i[vga_pkg::STAT_VIF]);
    end else begin
      hif_q <= hif_q | hend_i;
      vif_q <= vif_q | vend_i;
    end
  end

  // flags always set, enables only mask the pin
  assign irq_o = (hie_q & hif_q) | (vie_q & vif_q);

  ////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    prdata_o = '0;
    if (rd_acc) begin
      case (reg_idx)
        vga_pkg::REG_CTRL: begin
          prdata_o[vga_pkg::CTRL_EN]    = en_o;
          prdata_o[vga_pkg::CTRL_HIE]   = hie_q;
          prdata_o[vga_pkg::CTRL_VIE]   = vie_q;
          prdata_o[vga_pkg::CTRL_HSPOL] = hspol_o;
          prdata_o[vga_pkg::CTRL_VSPOL] = vspol_o;
          prdata_o[vga_pkg::CTRL_DIV_LSB +: vga_pkg::DIV_W] = div_o;
        end
        vga_pkg::REG_HVVL: begin
          prdata_o[vga_pkg::HVVL_HV_LSB +: vga_pkg::LEN_W] = hvlen_o;
          prdata_o[vga_pkg::HVVL_VV_LSB +: vga_pkg::LEN_W] = vvlen_o;
        end
        vga_pkg::REG_HTIM: begin
          prdata_o[vga_pkg::TIM_FP_LSB +: vga_pkg::PORCH_W] = hfp_o;
          prdata_o[vga_pkg::TIM_SN_LSB +: vga_pkg::PORCH_W] = hsn_o;
          prdata_o[vga_pkg::TIM_BP_LSB +: vga_pkg::PORCH_W] = hbp_o;
        end
        vga_pkg::REG_VTIM: begin
          prdata_o[vga_pkg::TIM_FP_LSB +: vga_pkg::PORCH_W] = vfp_o;
          prdata_o[vga_pkg::TIM_SN_LSB +: vga_pkg::PORCH_W] = vsn_o;
          prdata_o[vga_pkg::TIM_BP_LSB +: vga_pkg::PORCH_W] = vbp_o;
        end
        vga_pkg::REG_STAT: begin
          prdata_o[vga_pkg::STAT_HIF] = hif_q;
          prdata_o[vga_pkg::STAT_VIF] = vif_q;
        end
        default: prdata_o = '0;
      endcase
    end
  end

  // the timing stages need a nonzero sync and visible size while running
  a_sizes_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    en_o |-> (hsn_o != '0) && (vsn_o != '0) && (hvlen_o != '0) && (vvlen_o != '0));

endmodule

`default_nettype wire

/* logic/vga_pixel_tick.sv */
// pixel step strobe, one clock high every div+1 clocks while enabled
// a new divider value is picked up at the next reload

`timescale 1ns/1ps
`default_nettype none

module vga_pixel_tick (
  input  wire logic                       clk_i,
  input  wire logic                       arst_n_i,
  input  wire logic                       en_i,
  input  wire logic [vga_pkg::DIV_W-1:0]  div_i,
  output logic                            tick_o
);

  logic [vga_pkg::DIV_W-1:0] cnt_q;
  logic                      zero;

  assign zero = (cnt_q == '0);

  // down counter, parked at the reload value while disabled
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (!en_i) begin
      cnt_q <= div_i;
    end else if (zero) begin
      cnt_q <= div_i;
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // div of 0 gives a tick on every enabled clock
  assign tick_o = en_i & zero;

  // with a nonzero divider a tick is a single-clock pulse
  a_tick_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tick_o && (div_i != '0) |=> !tick_o);

endmodule

`default_nettype wire

/* logic/vga_timing_gen.sv */
// one sync/back/visible/front sequencer, used for both lines and frames
// a zero porch is skipped; sync and visible sizes must be nonzero

`timescale 1ns/1ps
`default_nettype none

module vga_timing_gen #(
  parameter int CNT_W = 16
) (
  input  wire logic                         clk_i,
  input  wire logic                         arst_n_i,
  input  wire logic                         en_i,
  input  wire logic                         step_i,
  input  wire logic [vga_pkg::PORCH_W-1:0]  sync_size_i,
  input  wire logic [vga_pkg::PORCH_W-1:0]  back_size_i,
  input  wire logic [vga_pkg::PORCH_W-1:0]  front_size_i,
  input  wire logic [CNT_W-1:0]             vis_len_i,
  output vga_pkg::phase_e                   phase_o,
  output logic      [CNT_W-1:0]             pos_o,
  output logic                              end_o
);

  vga_pkg::phase_e  phase_q;
  vga_pkg::phase_e  next_ph;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cur_size;
  logic             last;

  ////////////////////////////////////////////////////////////
  // size of the current phase and the phase after it
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (phase_q)
      vga_pkg::PH_SYNC:    cur_size = CNT_W'(sync_size_i);
      vga_pkg::PH_BACK:    cur_size = CNT_W'(back_size_i);
      vga_pkg::PH_VISIBLE: cur_size = vis_len_i;
      default:             cur_size = CNT_W'(front_size_i);
    endcase
  end

  always_comb begin
    case (phase_q)
      vga_pkg::PH_SYNC:
        next_ph = (back_size_i != '0) ? vga_pkg::PH_BACK : vga_pkg::PH_VISIBLE;
      vga_pkg::PH_BACK:
        next_ph = vga_pkg::PH_VISIBLE;
      vga_pkg::PH_VISIBLE:
        next_ph = (front_size_i != '0) ? vga_pkg::PH_FRONT : vga_pkg::PH_SYNC;
      default:
        next_ph = vga_pkg::PH_SYNC;
    endcase
  end

  // one extra bit so the compare cannot overflow at full count
  assign last = ({1'b0, cnt_q} + 1'b1) >= {1'b0, cur_size};

  ////////////////////////////////////////////////////////////
  // phase and position state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q <= vga_pkg::PH_SYNC;
      cnt_q   <= '0;
    end else if (!en_i) begin
      // hold at the start of sync until enabled
      phase_q <= vga_pkg::PH_SYNC;
      cnt_q   <= '0;
    end else if (step_i) begin
      if (last) begin
        phase_q <= next_ph;
        cnt_q   <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign phase_o = phase_q;
  // index into the visible region only
  assign pos_o   = (phase_q == vga_pkg::PH_VISIBLE) ? cnt_q : '0;
  // the step that leaves the last front porch unit
  assign end_o   = step_i & last & (next_ph == vga_pkg::PH_SYNC);

  // sync and visible each take a step, so two wraps never come back to back
  a_end_spaced: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    end_o |=> !end_o);

endmodule

`default_nettype wire

/* logic/vga_video_out.sv */
// registered video pins, one clock behind the timing state
// the pattern pixel is the only source; rgb is forced to 0 outside de

`timescale 1ns/1ps
`default_nettype none

module vga_video_out (
  input  wire logic                         clk_i,
  input  wire logic                         arst_n_i,
  input  wire logic                         en_i,
  input  wire logic                         hspol_i,
  input  wire logic                         vspol_i,
  input  wire vga_pkg::phase_e              hphase_i,
  input  wire vga_pkg::phase_e              vphase_i,
  input  wire logic [vga_pkg::LEN_W-1:0]    x_i,
  input  wire logic [vga_pkg::LEN_W-1:0]    y_i,
  output logic                              hsync_o,
  output logic                              vsync_o,
  output logic                              de_o,
  output logic      [vga_pkg::COLOR_W-1:0]  r_o,
  output logic      [vga_pkg::COLOR_W-1:0]  g_o,
  output logic      [vga_pkg::COLOR_W-1:0]  b_o
);

  logic                        hs_act;
  logic                        vs_act;
  logic                        de_d;
  logic [vga_pkg::LEN_W-1:0]   xy;

  // active-high syncs before the polarity flip
  assign hs_act = en_i & (hphase_i == vga_pkg::PH_SYNC);
  assign vs_act = en_i & (vphase_i == vga_pkg::PH_SYNC);
  // both counters inside their visible region
  assign de_d   = en_i & (hphase_i == vga_pkg::PH_VISIBLE) &
                  (vphase_i == vga_pkg::PH_VISIBLE);
  assign xy     = x_i ^ y_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
      de_o    <= 1'b0;
      r_o     <= '0;
      g_o     <= '0;
      b_o     <= '0;
    end else begin
      // polarity bit set gives an active-low sync
      hsync_o <= hs_act ^ hspol_i;
      vsync_o <= vs_act ^ vspol_i;
      de_o    <= de_d;
      if (de_d) begin
        r_o <= x_i[vga_pkg::COLOR_W-1:0];
        g_o <= y_i[vga_pkg::COLOR_W-1:0];
        b_o <= xy[vga_pkg::COLOR_W-1:0];
      end else begin
        r_o <= '0;
        g_o <= '0;
        b_o <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/vga_top.sv */
// display timing controller with apb registers and a test pattern source
// single clock domain; pixel rate is clk_i divided by div+1

`timescale 1ns/1ps
`default_nettype none

module vga_top (
  input  wire logic                         clk_i,
  input  wire logic                         arst_n_i,
  input  wire logic                         psel_i,
  input  wire logic                         penable_i,
  input  wire logic                         pwrite_i,
  input  wire logic [vga_pkg::ADDR_W-1:0]   paddr_i,
  input  wire logic [vga_pkg::DATA_W-1:0]   pwdata_i,
  output logic      [vga_pkg::DATA_W-1:0]   prdata_o,
  output logic                              hsync_o,
  output logic                              vsync_o,
  output logic                              de_o,
  output logic      [vga_pkg::COLOR_W-1:0]  r_o,
  output logic      [vga_pkg::COLOR_W-1:0]  g_o,
  output logic      [vga_pkg::COLOR_W-1:0]  b_o,
  output logic                              irq_o
);

  logic                        en;
  logic                        hspol;
  logic                        vspol;
  logic [vga_pkg::DIV_W-1:0]   div;
  logic                        tick;
  // per stage sizes, index 0 horizontal and 1 vertical
  logic [vga_pkg::PORCH_W-1:0] sync_size  [2];
  logic [vga_pkg::PORCH_W-1:0] back_size  [2];
  logic [vga_pkg::PORCH_W-1:0] front_size [2];
  logic [vga_pkg::LEN_W-1:0]   vis_len    [2];
  logic                        stage_step [2];
  logic                        stage_end  [2];
  logic [vga_pkg::LEN_W-1:0]   stage_pos  [2];
  vga_pkg::phase_e             stage_ph   [2];

  vga_regs u_regs (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .hend_i    (stage_end[0]),
    .vend_i    (stage_end[1]),
    .prdata_o  (prdata_o),
    .en_o      (en),
    .hspol_o   (hspol),
    .vspol_o   (vspol),
    .div_o     (div),
    .hvlen_o   (vis_len[0]),
    .vvlen_o   (vis_len[1]),
    .hsn_o     (sync_size[0]),
    .hbp_o     (back_size[0]),
    .hfp_o     (front_size[0]),
    .vsn_o     (sync_size[1]),
    .vbp_o     (back_size[1]),
    .vfp_o     (front_size[1]),
    .irq_o     (irq_o)
  );

  vga_pixel_tick u_tick (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .en_i     (en),
    .div_i    (div),
    .tick_o   (tick)
  );

  ////////////////////////////////////////////////////////////
  // timing chain, each stage steps on the end of the one before
  ////////////////////////////////////////////////////////////

  assign stage_step[0] = tick;
  assign stage_step[1] = stage_end[0];

  for (genvar i = 0; i < 2; i++) begin : g_stage
    vga_timing_gen #(
      .CNT_W (vga_pkg::LEN_W)
    ) u_timing (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .en_i         (en),
      .step_i       (stage_step[i]),
      .sync_size_i  (sync_size[i]),
      .back_size_i  (back_size[i]),
      .front_size_i (front_size[i]),
      .vis_len_i    (vis_len[i]),
      .phase_o      (stage_ph[i]),
      .pos_o        (stage_pos[i]),
      .end_o        (stage_end[i])
    );
  end

  vga_video_out u_video (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .en_i     (en),
    .hspol_i  (hspol),
    .vspol_i  (vspol),
    .hphase_i (stage_ph[0]),
    .vphase_i (stage_ph[1]),
    .x_i      (stage_pos[0]),
    .y_i      (stage_pos[1]),
    .hsync_o  (hsync_o),
    .vsync_o  (vsync_o),
    .de_o     (de_o),
    .r_o      (r_o),
    .g_o      (g_o),
    .b_o      (b_o)
  );

endmodule

`default_nettype wire

/* bench/vga_tb_clk.sv */
// testbench clock and reset source
// reset is asserted at time 0 and released on a falling edge

`timescale 1ns/1ps
`default_nettype none

module vga_tb_clk #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic arst_n_o
);

  // free-running clock, low at time 0
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset held over the given number of rising edges
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* bench/vga_tb.sv */
// self-checking testbench for the display timing controller
// sizes are kept small so every test runs a few whole frames quickly
// inputs change on the falling edge, the pin monitor samples on the rising edge

`timescale 1ns/1ps
`default_nettype none

module vga_tb;

  localparam int CW             = vga_pkg::COLOR_W;
  localparam int N_CFG          = 4;
  // frames budgeted per run in the watchdog limit
  localparam int FRAMES_PER_RUN = 3;

  logic                        clk;
  logic                        arst_n;
  logic                        psel;
  logic                        penable;
  logic                        pwrite;
  logic [vga_pkg::ADDR_W-1:0]  paddr;
  logic [vga_pkg::DATA_W-1:0]  pwdata;
  logic [vga_pkg::DATA_W-1:0]  prdata;
  logic                        hsync;
  logic                        vsync;
  logic                        de;
  logic [CW-1:0]               r;
  logic [CW-1:0]               g;
  logic [CW-1:0]               b;
  logic                        irq;

  // timing configs, picked once at the start
  int c_div [N_CFG];
  int c_hsn [N_CFG];
  int c_hbp [N_CFG];
  int c_hv  [N_CFG];
  int c_hfp [N_CFG];
  int c_vsn [N_CFG];
  int c_vbp [N_CFG];
  int c_vv  [N_CFG];
  int c_vfp [N_CFG];

  // config the monitor measures against
  int   cur;
  logic cur_hspol;
  logic cur_vspol;

  // pin monitor state
  bit   mon_on;
  logic h_prev;
  logic v_prev;
  logic de_prev;
  bit   h_seen;
  bit   v_seen;
  int   h_rise;
  int   v_rise;
  int   de_run;
  int   de_lines;
  int   h_periods;
  int   v_periods;

  int cyc = 0;
  int limit = 0;
  int errors;
  int err_mark;
  int n_tests;
  int n_failed;

  vga_tb_clk #(
    .PERIOD_NS  (40),
    .RST_CYCLES (3)
  ) u_clk (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  vga_top dut0 (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .hsync_o   (hsync),
    .vsync_o   (vsync),
    .de_o      (de),
    .r_o       (r),
    .g_o       (g),
    .b_o       (b),
    .irq_o     (irq)
  );

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // clocks per line, every step lasts div+1 clocks
  function automatic int ref_line(input int i);
    return (c_div[i] + 1) * (c_hsn[i] + c_hbp[i] + c_hv[i] + c_hfp[i]);
  endfunction

  // clocks per frame
  function automatic int ref_frame(input int i);
    return ref_line(i) * (c_vsn[i] + c_vbp[i] + c_vv[i] + c_vfp[i]);
  endfunction

  // pattern: red from x, green from y, blue from x xor y
  function automatic logic [3*CW-1:0] ref_pixel(input int x, input int y);
    int xy;
    xy = x ^ y;
    return {x[CW-1:0], y[CW-1:0], xy[CW-1:0]};
  endfunction

  // defined bits of each register word
  function automatic logic [vga_pkg::DATA_W-1:0] reg_mask(input int idx);
    case (idx)
      vga_pkg::REG_CTRL: return 32'h0000_ff1f;
      vga_pkg::REG_HVVL: return 32'hffff_ffff;
      vga_pkg::REG_HTIM: return 32'h00ff_ffff;
      vga_pkg::REG_VTIM: return 32'h00ff_ffff;
      default:           return 32'h0000_0003;
    endcase
  endfunction

  function automatic logic [vga_pkg::ADDR_W-1:0] addr_of(input int idx);
    return idx[2:0] << 2;
  endfunction

  function automatic logic [vga_pkg::DATA_W-1:0] ctrl_word(input int i, input bit en,
      input bit hie, input bit vie, input bit hspol, input bit vspol);
    logic [vga_pkg::DATA_W-1:0] w;
    w = '0;
    w[vga_pkg::CTRL_EN]    = en;
    w[vga_pkg::CTRL_HIE]   = hie;
    w[vga_pkg::CTRL_VIE]   = vie;
    w[vga_pkg::CTRL_HSPOL] = hspol;
    w[vga_pkg::CTRL_VSPOL] = vspol;
    w[vga_pkg::CTRL_DIV_LSB +: vga_pkg::DIV_W] = c_div[i][vga_pkg::DIV_W-1:0];
    return w;
  endfunction

  // porch and sync word, front porch lowest
  function automatic logic [vga_pkg::DATA_W-1:0] tim_word(input int bp, input int sn,
      input int fp);
    logic [vga_pkg::DATA_W-1:0] w;
    w = '0;
    w[vga_pkg::TIM_FP_LSB +: vga_pkg::PORCH_W] = fp[vga_pkg::PORCH_W-1:0];
    w[vga_pkg::TIM_SN_LSB +: vga_pkg::PORCH_W] = sn[vga_pkg::PORCH_W-1:0];
    w[vga_pkg::TIM_BP_LSB +: vga_pkg::PORCH_W] = bp[vga_pkg::PORCH_W-1:0];
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_word(input logic [vga_pkg::DATA_W-1:0] got,
      input logic [vga_pkg::DATA_W-1:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      errors++;
      $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_pixel(input logic [CW-1:0] got, input logic [CW-1:0] exp,
      input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s channel is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // apb access and run control
  ////////////////////////////////////////////////////////////

  task automatic apb_write(input int idx, input logic [vga_pkg::DATA_W-1:0] data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr_of(idx);
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // data is taken mid-cycle, while the access phase is still driven
  task automatic apb_read(input int idx, output logic [vga_pkg::DATA_W-1:0] data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr_of(idx);
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    data    = prdata;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic arm_monitor();
    h_prev    = 1'b0;
    v_prev    = 1'b0;
    de_prev   = 1'b0;
    h_seen    = 1'b0;
    v_seen    = 1'b0;
    de_run    = 0;
    de_lines  = 0;
    h_periods = 0;
    v_periods = 0;
    mon_on    = 1'b1;
  endtask

  // program config i disabled, let the idle levels settle, then enable
  task automatic start_config(input int i, input bit hie, input bit vie,
      input bit hspol, input bit vspol);
    logic [vga_pkg::DATA_W-1:0] ctrl;
    mon_on    = 1'b0;
    cur       = i;
    cur_hspol = hspol;
    cur_vspol = vspol;
    ctrl = ctrl_word(i, 1'b0, hie, vie, hspol, vspol);
    apb_write(vga_pkg::REG_CTRL, ctrl);
    apb_write(vga_pkg::REG_HVVL, {c_vv[i][15:0], c_hv[i][15:0]});
    apb_write(vga_pkg::REG_HTIM, tim_word(c_hbp[i], c_hsn[i], c_hfp[i]));
    apb_write(vga_pkg::REG_VTIM, tim_word(c_vbp[i], c_vsn[i], c_vfp[i]));
    repeat (2) @(negedge clk);
    arm_monitor();
    ctrl[vga_pkg::CTRL_EN] = 1'b1;
    apb_write(vga_pkg::REG_CTRL, ctrl);
  endtask

  task automatic wait_frames(input int n);
    while (v_periods < n) @(negedge clk);
  endtask

  task automatic mark_start();
    err_mark = errors;
  endtask

  task automatic report_test(input string name);
    n_tests++;
    if (errors == err_mark) begin
      $display("test %-10s ok", name);
    end else begin
      n_failed++;
      $display("test %-10s failed with %0d errors", name, errors - err_mark);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // pin monitor
  ////////////////////////////////////////////////////////////

  always @(posedge clk) cyc <= cyc + 1;

  always @(posedge clk) begin : monitor
    logic            h_act;
    logic            v_act;
    logic [3*CW-1:0] px;
    int              d;
    if (mon_on) begin
      d     = c_div[cur] + 1;
      h_act = hsync ^ cur_hspol;
      v_act = vsync ^ cur_vspol;
      // pixels first, so a line ending here is counted before a frame edge
      if (de) begin
        px = ref_pixel(de_run / d, de_lines);
        check_pixel(r, px[3*CW-1 -: CW], "red");
        check_pixel(g, px[2*CW-1 -: CW], "green");
        check_pixel(b, px[CW-1:0], "blue");
        de_run++;
      end else begin
        if (de_prev) begin
          check_count(de_run, d * c_hv[cur], "de clocks per line");
          de_lines++;
        end
        de_run = 0;
        check_pixel(r, '0, "red outside de");
        check_pixel(g, '0, "green outside de");
        check_pixel(b, '0, "blue outside de");
      end
      // line timing between active hsync edges
      if (h_act && !h_prev) begin
        if (h_seen) begin
          check_count(cyc - h_rise, ref_line(cur), "hsync period");
          h_periods++;
        end
        h_seen = 1'b1;
        h_rise = cyc;
      end else if (!h_act && h_prev && h_seen) begin
        check_count(cyc - h_rise, d * c_hsn[cur], "hsync width");
      end
      // frame timing and active lines per frame
      if (v_act && !v_prev) begin
        if (v_seen) begin
          check_count(cyc - v_rise, ref_frame(cur), "vsync period");
          check_count(de_lines, c_vv[cur], "active lines per frame");
          v_periods++;
        end
        v_seen   = 1'b1;
        v_rise   = cyc;
        de_lines = 0;
      end else if (!v_act && v_prev && v_seen) begin
        check_count(cyc - v_rise, ref_line(cur) * c_vsn[cur], "vsync width");
      end
      h_prev  = h_act;
      v_prev  = v_act;
      de_prev = de;
    end
  end

  // run limit from the frame lengths of all runs
  initial begin : watchdog
    wait (limit > 0);
    while (cyc < limit) @(posedge clk);
    $display("timeout: run did not finish within %0d clocks", limit);
    $display("FAIL: see errors above");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    logic [vga_pkg::DATA_W-1:0] wdata;
    logic [vga_pkg::DATA_W-1:0] rdata;
    int                         total;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    mon_on    = 1'b0;
    cur       = 0;
    cur_hspol = 1'b0;
    cur_vspol = 1'b0;
    errors    = 0;
    n_tests   = 0;
    n_failed  = 0;
    void'($urandom(32'hee3cf723));
    total = 0;
    for (int i = 0; i < N_CFG; i++) begin
      c_div[i] = $urandom_range(2, 0);
      c_hsn[i] = $urandom_range(4, 1);
      c_hbp[i] = $urandom_range(3, 0);
      c_hv[i]  = $urandom_range(8, 2);
      c_hfp[i] = $urandom_range(3, 0);
      c_vsn[i] = $urandom_range(3, 1);
      c_vbp[i] = $urandom_range(2, 0);
      c_vv[i]  = $urandom_range(5, 2);
      c_vfp[i] = $urandom_range(2, 0);
      total += ref_frame(i);
    end
    // four timing runs, plus interrupt and disable runs on configs 0 and 3
    limit = 2 * FRAMES_PER_RUN * (total + ref_frame(0) + ref_frame(3)) + 1000;
    wait (arst_n === 1'b1);

    // register readback, controller kept disabled
    mark_start();
    for (int k = 0; k < 4; k++) begin
      for (int idx = 0; idx < 4; idx++) begin
        wdata = $urandom();
        if (idx == vga_pkg::REG_CTRL) begin
          wdata[vga_pkg::CTRL_EN] = 1'b0;
        end
        apb_write(idx, wdata);
        apb_read(idx, rdata);
        check_word(rdata, wdata & reg_mask(idx), "register readback");
      end
    end
    for (int idx = 5; idx < 8; idx++) begin
      apb_write(idx, $urandom());
      apb_read(idx, rdata);
      check_word(rdata, '0, "undefined address");
    end
    apb_read(vga_pkg::REG_STAT, rdata);
    check_word(rdata, '0, "status after reset");
    report_test("readback");

    // line, frame and pixel timing, every polarity combination
    for (int i = 0; i < N_CFG; i++) begin
      mark_start();
      start_config(i, 1'b0, 1'b0, i[0], i[1]);
      wait_frames(2);
      mon_on = 1'b0;
      report_test($sformatf("timing %0d", i));
    end

    // stop the last timing run and drop the flags it left behind
    mark_start();
    apb_write(vga_pkg::REG_CTRL, ctrl_word(0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0));
    apb_write(vga_pkg::REG_STAT, 32'h0);
    apb_read(vga_pkg::REG_STAT, rdata);
    check_word(rdata, 32'h0, "status before interrupt run");
    check_count(irq, 0, "irq with flags clear");
    // interrupts enabled, the first line end raises irq
    start_config(0, 1'b1, 1'b1, 1'b0, 1'b0);
    while (irq !== 1'b1) @(negedge clk);
    apb_read(vga_pkg::REG_STAT, rdata);
    check_word(rdata & 32'h1, 32'h1, "line flag after irq");
    wait_frames(1);
    mon_on = 1'b0;
    apb_write(vga_pkg::REG_CTRL, ctrl_word(0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0));
    apb_read(vga_pkg::REG_STAT, rdata);
    check_word(rdata, 32'h3, "flags after a frame");
    // 1 keeps the line flag, 0 clears the frame flag
    apb_write(vga_pkg::REG_STAT, 32'h1);
    apb_read(vga_pkg::REG_STAT, rdata);
    check_word(rdata, 32'h1, "status after partial clear");
    check_count(irq, 1, "irq held by line flag");
    apb_write(vga_pkg::REG_STAT, 32'h0);
    apb_read(vga_pkg::REG_STAT, rdata);
    check_word(rdata, 32'h0, "status after clear");
    check_count(irq, 0, "irq after clear");
    // enables clear, flags still set but the pin stays low
    start_config(0, 1'b0, 1'b0, 1'b0, 1'b0);
    while (v_periods < 1) begin
      @(negedge clk);
      check_count(irq, 0, "irq with enables clear");
    end
    mon_on = 1'b0;
    apb_write(vga_pkg::REG_CTRL, ctrl_word(0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    apb_read(vga_pkg::REG_STAT, rdata);
    check_word(rdata, 32'h3, "flags set while masked");
    apb_write(vga_pkg::REG_STAT, 32'h0);
    report_test("interrupts");

    // disable mid-frame, idle pins, then restart from the line start
    mark_start();
    start_config(3, 1'b0, 1'b0, 1'b1, 1'b1);
    wait_frames(1);
    mon_on = 1'b0;
    apb_write(vga_pkg::REG_CTRL, ctrl_word(3, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1));
    repeat (2) @(negedge clk);
    check_count(de, 0, "de while disabled");
    check_pixel(r, '0, "red while disabled");
    check_pixel(g, '0, "green while disabled");
    check_pixel(b, '0, "blue while disabled");
    check_count(hsync, 1, "idle hsync level");
    check_count(vsync, 1, "idle vsync level");
    arm_monitor();
    apb_write(vga_pkg::REG_CTRL, ctrl_word(3, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1));
    while (h_periods < 1) @(negedge clk);
    mon_on = 1'b0;
    report_test("disable");

    $display("%0d tests run, %0d failed, %0d errors", n_tests, n_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
logic/vga_pkg.sv
logic/vga_regs.sv
logic/vga_pixel_tick.sv
logic/vga_timing_gen.sv
logic/vga_video_out.sv
logic/vga_top.sv
bench/vga_tb_clk.sv
bench/vga_tb.sv

/* Bender.yml */
package:
  name: vga_timing

sources:
  - logic/vga_pkg.sv
  - logic/vga_regs.sv
  - logic/vga_pixel_tick.sv
  - logic/vga_timing_gen.sv
  - logic/vga_video_out.sv
  - logic/vga_top.sv
  - target: test
    files:
      - bench/vga_tb_clk.sv
      - bench/vga_tb.sv
